// File: Bender.yml
package:
  name: cart_mappers

sources:
  - hw/cart_pkg.sv
  - hw/cpu_bus_sample.sv
  - hw/mapper_ascii8.sv
  - hw/mapper_ascii16.sv
  - hw/mapper_konami_scc.sv
  - hw/mapper_merge.sv
  - hw/cart_mappers.sv
  - target: simulation
    files:
      - dv/cart_mappers_tb.sv

// File: all.f
hw/cart_pkg.sv
hw/cpu_bus_sample.sv
hw/mapper_ascii8.sv
hw/mapper_ascii16.sv
hw/mapper_konami_scc.sv
hw/mapper_merge.sv
hw/cart_mappers.sv
dv/cart_mappers_tb.sv

// File: dv/cart_mappers_tb.sv
`timescale 1ns/1ns

module cart_mappers_tb;

    typedef enum logic [1:0] {
        OP_RD,  // Read, full compare
        OP_WR,  // Write, full compare
        OP_BW   // Bank register write, selects only
    } op_t;

    typedef struct packed {
        cart_pkg::mapper_t   typ;
        logic                sram_en;
        op_t                 op;
        cart_pkg::cpu_addr_t addr;
        cart_pkg::cpu_data_t data;
        cart_pkg::mem_addr_t exp_addr;
        logic                ram_cs;
        logic                sram_cs;
        logic                rnw;
        logic                dev_en;   // Expected SCC window enable
    } step_t;

    localparam cart_pkg::mapper_t   M_NONE  = cart_pkg::MAPPER_NONE;
    localparam cart_pkg::mapper_t   M_A8    = cart_pkg::MAPPER_ASCII8;
    localparam cart_pkg::mapper_t   M_A16   = cart_pkg::MAPPER_ASCII16;
    localparam cart_pkg::mapper_t   M_SCC   = cart_pkg::MAPPER_KONAMI_SCC;
    localparam cart_pkg::mem_addr_t MEM_BASE = 25'h0100000;
    localparam cart_pkg::mem_addr_t ROM_MASK = 25'h001FFFF;  // 128 KiB image
    localparam cart_pkg::mem_addr_t ONES     = 25'h1FFFFFF;  // Idle address
    localparam int N_TABLE = 51;
    localparam int N_RAND_ROUNDS = 2;

    // typ, sram_en, op, addr, data, exp_addr, ram_cs, sram_cs, rnw, dev_en
    localparam step_t TABLE [N_TABLE] = '{
        '{M_NONE, 1'b0, OP_RD, 16'h4000, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_NONE, 1'b0, OP_RD, 16'h8000, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_NONE, 1'b0, OP_RD, 16'hBFFF, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_NONE, 1'b0, OP_RD, 16'h0000, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        // Konami SCC, banks 0..3 after reset
        '{M_SCC,  1'b0, OP_RD, 16'h6000, 8'h00, 25'h0102000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h4010, 8'h00, 25'h0100010, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'hA004, 8'h00, 25'h0106004, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_BW, 16'h7000, 8'h05, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h6100, 8'h00, 25'h010A100, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h4000, 8'h00, 25'h0100000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h8000, 8'h00, 25'h0104000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'hA000, 8'h00, 25'h0106000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_BW, 16'h5000, 8'h0A, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h4020, 8'h00, 25'h0114020, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h6000, 8'h00, 25'h010A000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_BW, 16'hB000, 8'h11, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'hA001, 8'h00, 25'h0102001, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h8000, 8'h00, 25'h0104000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_BW, 16'h9000, 8'h3F, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h9800, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b1},
        '{M_SCC,  1'b0, OP_WR, 16'h9810, 8'h55, ONES,        1'b0, 1'b0, 1'b1, 1'b1},
        '{M_SCC,  1'b0, OP_RD, 16'h8000, 8'h00, 25'h011E000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_BW, 16'h9000, 8'h3E, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h9800, 8'h00, 25'h011D800, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'hC000, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_SCC,  1'b0, OP_RD, 16'h3FFF, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        // ASCII8, bank 3 at 85h is SRAM
        '{M_A8,   1'b1, OP_BW, 16'h6000, 8'h03, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_BW, 16'h6800, 8'h04, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_BW, 16'h7000, 8'h12, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_BW, 16'h7800, 8'h85, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_RD, 16'h4000, 8'h00, 25'h0106000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_RD, 16'h7FFF, 8'h00, 25'h0109FFF, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_RD, 16'h8123, 8'h00, 25'h0104123, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_RD, 16'hA010, 8'h00, 25'h0100010, 1'b0, 1'b1, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_WR, 16'hA020, 8'h77, 25'h0100020, 1'b0, 1'b1, 1'b0, 1'b0},
        '{M_A8,   1'b1, OP_RD, 16'hC000, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A8,   1'b1, OP_WR, 16'h1000, 8'h33, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        // ASCII16, two 16 KiB pages
        '{M_A16,  1'b1, OP_RD, 16'h4000, 8'h00, 25'h0100000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_BW, 16'h6000, 8'h02, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_BW, 16'h7000, 8'h03, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'h4100, 8'h00, 25'h0108100, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'h8200, 8'h00, 25'h010C200, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'hBFFF, 8'h00, 25'h010FFFF, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_BW, 16'h7000, 8'h80, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'h8004, 8'h00, 25'h0100004, 1'b0, 1'b1, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_WR, 16'h8000, 8'h5A, 25'h0100000, 1'b0, 1'b1, 1'b0, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'h4000, 8'h00, 25'h0108000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_BW, 16'h6000, 8'h09, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'h4000, 8'h00, 25'h0104000, 1'b1, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'hFFFF, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0},
        '{M_A16,  1'b1, OP_RD, 16'h2000, 8'h00, ONES,        1'b0, 1'b0, 1'b1, 1'b0}
    };

    logic                  clk = 1'b0;
    logic                  rst;
    cart_pkg::cpu_bus_t    cpu;
    cart_pkg::block_info_t block_info;
    cart_pkg::memory_bus_t memory_bus;
    cart_pkg::device_bus_t device_bus;

    step_t       steps [$];           // Table plus random ASCII8 steps
    int          cycle_cnt = 0;
    int          timeout_cycles = 1000;
    logic [31:0] seed;
    step_t       st;
    cart_pkg::bank_t v;
    logic [12:0] off;

    always #20 clk = ~clk;  // 40 ns period

    cart_mappers #(.ADDR_W(25)) cart_mappers_i (
        .clk(clk), .rst(rst), .cpu(cpu), .block_info(block_info),
        .memory_bus(memory_bus), .device_bus(device_bus)
    );

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            stop_with_failure();
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cart_pkg::block_info_t config_for(input cart_pkg::mapper_t typ,
                                                         input logic sram_en);
        cart_pkg::block_info_t cfg;
        cfg.typ      = typ;
        cfg.device   = (typ == M_SCC) ? cart_pkg::DEV_SCC : cart_pkg::DEV_NONE;
        cfg.sram_en  = sram_en;
        cfg.mem_base = MEM_BASE;
        cfg.rom_mask = ROM_MASK;
        return cfg;
    endfunction

    task automatic check_mem(input cart_pkg::memory_bus_t exp, input cart_pkg::memory_bus_t act,
                             input bit with_addr);
        bit bad;
        bad = 1'b0;
        if (with_addr && act.addr !== exp.addr) begin
            $display("ERR %0t memory_bus.addr exp %h act %h", $time, exp.addr, act.addr);
            bad = 1'b1;
        end
        if ({act.ram_cs, act.sram_cs, act.rnw} !== {exp.ram_cs, exp.sram_cs, exp.rnw}) begin
            $display("ERR %0t memory_bus.ram_cs/sram_cs/rnw exp %b%b%b act %b%b%b", $time,
                     exp.ram_cs, exp.sram_cs, exp.rnw, act.ram_cs, act.sram_cs, act.rnw);
            bad = 1'b1;
        end
        if (bad) stop_with_failure();
    endtask

    task automatic check_dev(input cart_pkg::device_bus_t exp, input cart_pkg::device_bus_t act);
        if (act !== exp) begin
            $display("ERR %0t device_bus exp %h act %h", $time, exp, act);
            stop_with_failure();
        end
    endtask

    // Reset with the new config loaded while rst is high
    task automatic apply_reset(input cart_pkg::block_info_t cfg);
        @(posedge clk);
        #2 rst = 1'b1;
        @(posedge clk);
        #2 block_info = cfg;
        repeat (9) @(posedge clk);
        #2 rst = 1'b0;
    endtask

    // Two cycles of access, then one idle cycle
    task automatic run_step(input step_t s);
        cart_pkg::memory_bus_t exp_mem;
        cart_pkg::device_bus_t exp_dev;
        cart_pkg::memory_bus_t idle_mem;
        cart_pkg::device_bus_t idle_dev;
        exp_mem.addr     = s.exp_addr;
        exp_mem.ram_cs   = s.ram_cs;
        exp_mem.sram_cs  = s.sram_cs;
        exp_mem.rnw      = s.rnw;
        exp_dev.typ      = (s.typ == M_SCC) ? cart_pkg::DEV_SCC : cart_pkg::DEV_NONE;
        exp_dev.en       = s.dev_en;
        exp_dev.we       = s.dev_en & (s.op != OP_RD);
        idle_mem.addr    = ONES;  // Address is not compared while idle
        idle_mem.ram_cs  = 1'b0;
        idle_mem.sram_cs = 1'b0;
        idle_mem.rnw     = 1'b1;
        idle_dev.typ     = cart_pkg::DEV_NONE;  // No memory cycle, no device
        idle_dev.en      = 1'b0;
        idle_dev.we      = 1'b0;
        @(posedge clk);
        #2;
        cpu.addr = s.addr;
        cpu.data = s.data;
        cpu.mreq = 1'b1;
        cpu.wr   = s.op != OP_RD;
        cpu.rd   = s.op == OP_RD;
        #8;  // Registered bus still holds the idle cycle
        check_mem(idle_mem, memory_bus, 1'b0);
        check_dev(idle_dev, device_bus);
        @(posedge clk);
        #10;  // Mapping of the first sampled cycle
        check_mem(exp_mem, memory_bus, s.op != OP_BW);
        check_dev(exp_dev, device_bus);
        @(posedge clk);
        #2;
        cpu.mreq = 1'b0;
        cpu.wr   = 1'b0;
        cpu.rd   = 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        cpu        = '0;
        block_info = config_for(M_NONE, 1'b0);
        foreach (TABLE[i]) steps.push_back(TABLE[i]);
        // Random ASCII8 banks, values past 0Fh wrap on the 128 KiB mask
        seed = 32'h6c38f6e5;
        for (int r = 0; r < N_RAND_ROUNDS; r++) begin
            for (int k = 0; k < 4; k++) begin
                seed = xorshift32(seed);
                v    = seed[7:0];
                off  = seed[20:8];
                st   = '{typ: M_A8, sram_en: 1'b0, op: OP_BW, addr: 16'h6000 + 16'(k * 'h800),
                         data: v, exp_addr: ONES, ram_cs: 1'b0, sram_cs: 1'b0, rnw: 1'b1,
                         dev_en: 1'b0};
                steps.push_back(st);
                st.op       = OP_RD;
                st.addr     = 16'h4000 + 16'(k * 'h2000) + 16'(off);
                st.data     = 8'h00;
                st.exp_addr = MEM_BASE + (((cart_pkg::mem_addr_t'(v) << 13)
                                           + cart_pkg::mem_addr_t'(off)) & ROM_MASK);
                st.ram_cs   = 1'b1;
                steps.push_back(st);
            end
        end
        timeout_cycles = steps.size() * 4 + 50;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        foreach (steps[i]) begin
            if (steps[i].typ != block_info.typ || steps[i].sram_en != block_info.sram_en) begin
                apply_reset(config_for(steps[i].typ, steps[i].sram_en));
            end
            run_step(steps[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: hw/cart_mappers.sv
`timescale 1ns/1ns

module cart_mappers #(
    parameter int unsigned ADDR_W = 25
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cart_pkg::cpu_bus_t    cpu,
    input  cart_pkg::block_info_t block_info,
    output cart_pkg::memory_bus_t memory_bus,
    output cart_pkg::device_bus_t device_bus
);

    cart_pkg::cpu_bus_t    cpu_q;        // Registered CPU bus
    logic                  bank_wr;      // One pulse per bank write
    cart_pkg::mapper_out_t ascii8_out;
    cart_pkg::mapper_out_t ascii16_out;
    cart_pkg::mapper_out_t scc_out;
    logic                  scc_en;
    logic                  scc_we;

    cpu_bus_sample cpu_bus_sample_i (
        .clk(clk), .rst(rst), .cpu(cpu), .cpu_q(cpu_q), .bank_wr(bank_wr)
    );

    // All mappers see the same bus, only the selected one answers
    mapper_ascii8 #(.ADDR_W(ADDR_W)) mapper_ascii8_i (
        .clk(clk), .rst(rst), .cpu_q(cpu_q), .bank_wr(bank_wr),
        .block_info(block_info), .out(ascii8_out)
    );

    mapper_ascii16 #(.ADDR_W(ADDR_W)) mapper_ascii16_i (
        .clk(clk), .rst(rst), .cpu_q(cpu_q), .bank_wr(bank_wr),
        .block_info(block_info), .out(ascii16_out)
    );

    mapper_konami_scc #(.ADDR_W(ADDR_W)) mapper_konami_scc_i (
        .clk(clk), .rst(rst), .cpu_q(cpu_q), .bank_wr(bank_wr),
        .block_info(block_info), .out(scc_out),
        .scc_en(scc_en), .scc_we(scc_we)
    );

    mapper_merge #(.ADDR_W(ADDR_W)) mapper_merge_i (
        .ascii8_out(ascii8_out),
        .ascii16_out(ascii16_out),
        .scc_out(scc_out),
        .scc_en(scc_en),
        .scc_we(scc_we),
        .cpu_q(cpu_q),
        .block_info(block_info),
        .memory_bus(memory_bus),
        .device_bus(device_bus)
    );

endmodule

// File: hw/cart_pkg.sv
package cart_pkg;

    // Memory address width at the default top-level ADDR_W
    localparam int unsigned MEM_ADDR_W = 25;

    typedef logic [15:0]           cpu_addr_t;  // Z80 address
    typedef logic [7:0]            cpu_data_t;  // Z80 data
    typedef logic [7:0]            bank_t;      // Bank register value
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;  // Flat cartridge memory address

    // Active mapper of the slot
    typedef enum logic [1:0] {
        MAPPER_NONE       = 2'd0,
        MAPPER_ASCII8     = 2'd1,
        MAPPER_ASCII16    = 2'd2,
        MAPPER_KONAMI_SCC = 2'd3
    } mapper_t;

    // Device seen on the device bus
    typedef enum logic [1:0] {
        DEV_NONE = 2'd0,
        DEV_SCC  = 2'd1
    } device_t;

    // CPU side, plain levels
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t data;
        logic      mreq;
        logic      wr;
        logic      rd;
    } cpu_bus_t;

    // Static slot configuration, changes only in reset
    typedef struct packed {
        mapper_t   typ;
        device_t   device;
        logic      sram_en;   // Bank bit 7 may select SRAM
        mem_addr_t mem_base;  // Start of the image
        mem_addr_t rom_mask;  // Image size minus one
    } block_info_t;

    // Result of one mapper, all ones and no select when idle
    typedef struct packed {
        mem_addr_t addr;
        logic      ram_cs;
        logic      sram_cs;
        logic      rnw;
    } mapper_out_t;

    typedef struct packed {
        device_t typ;
        logic    en;
        logic    we;
    } device_bus_t;

    typedef mapper_out_t memory_bus_t;  // Merged result, same layout

    // ROM address: offset in the image wraps on rom_mask, then the base is added
    function automatic mem_addr_t rom_addr(input mem_addr_t mem_base,
                                           input mem_addr_t rom_mask,
                                           input mem_addr_t rom_off);
        return mem_base + (rom_off & rom_mask);
    endfunction

endpackage

// File: hw/cpu_bus_sample.sv
`timescale 1ns/1ns

module cpu_bus_sample (
    input  logic               clk,
    input  logic               rst,
    input  cart_pkg::cpu_bus_t cpu,
    output cart_pkg::cpu_bus_t cpu_q,
    output logic               bank_wr
);

    cart_pkg::cpu_addr_t addr_q;   // Payload, no reset
    cart_pkg::cpu_data_t data_q;
    logic                mreq_q;
    logic                wr_q;
    logic                rd_q;
    logic                wr_seen;  // Registered write was already active last cycle

    // Control levels
    always_ff @(posedge clk) begin
        if (rst) begin
            mreq_q  <= 1'b0;
            wr_q    <= 1'b0;
            rd_q    <= 1'b0;
            wr_seen <= 1'b0;
        end else begin
            mreq_q  <= cpu.mreq;
            wr_q    <= cpu.wr;
            rd_q    <= cpu.rd;
            wr_seen <= mreq_q & wr_q;  // Delayed copy for the edge detect
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= cpu.addr;
        data_q <= cpu.data;
    end

    assign cpu_q = '{
        addr: addr_q,
        data: data_q,
        mreq: mreq_q,
        wr:   wr_q,
        rd:   rd_q
    };

    // Rising edge of mreq and wr together
    // A long write loads the banks once
    assign bank_wr = mreq_q & wr_q & ~wr_seen;

    // One pulse per write, never stretched
    a_bank_wr_single: assert property (@(posedge clk) disable iff (rst)
        bank_wr |=> !bank_wr)
        else $error("bank_wr high on two consecutive cycles");

endmodule

// File: hw/mapper_ascii16.sv
`timescale 1ns/1ns

module mapper_ascii16 #(
    parameter int unsigned ADDR_W = 25
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cart_pkg::cpu_bus_t    cpu_q,
    input  logic                  bank_wr,
    input  cart_pkg::block_info_t block_info,
    output cart_pkg::mapper_out_t out
);

    cart_pkg::bank_t     bank [2];   // Pages 4000h and 8000h
    logic                sel;
    logic                in_range;
    cart_pkg::bank_t     cur_bank;
    logic                sram_sel;
    logic                sram_wr;
    cart_pkg::mem_addr_t rom_off;    // Bank times 16 KiB plus offset
    cart_pkg::mem_addr_t sram_addr;
    cart_pkg::mem_addr_t addr_full;

    assign sel      = block_info.typ == cart_pkg::MAPPER_ASCII16;
    assign in_range = cpu_q.addr[15] ^ cpu_q.addr[14];
    assign cur_bank = bank[cpu_q.addr[15]];  // addr[15] picks the 16 KiB page
    assign sram_sel = block_info.sram_en & cur_bank[7];
    assign sram_wr  = sram_sel & cpu_q.addr[15] & cpu_q.mreq & cpu_q.wr;

    // 6000h-67FFh loads bank 0, 7000h-77FFh loads bank 1
    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '{default: '0};
        end else if (sel && bank_wr) begin
            if (cpu_q.addr[15:11] == 5'b01100) bank[0] <= cpu_q.data;
            if (cpu_q.addr[15:11] == 5'b01110) bank[1] <= cpu_q.data;
        end
    end

    assign rom_off   = cart_pkg::mem_addr_t'({cur_bank, cpu_q.addr[13:0]});
    // SRAM sits at the image base, offset within 8 KiB
    assign sram_addr = block_info.mem_base + cart_pkg::mem_addr_t'(cpu_q.addr[12:0]);
    assign addr_full = sram_sel ? sram_addr
                                : cart_pkg::rom_addr(block_info.mem_base,
                                                     block_info.rom_mask, rom_off);

    always_comb begin
        out      = '0;
        out.addr = '1;
        out.rnw  = 1'b1;
        if (sel && in_range) begin
            out.addr[ADDR_W-1:0] = addr_full[ADDR_W-1:0];
            out.ram_cs           = cpu_q.mreq & cpu_q.rd & ~sram_sel;
            out.sram_cs          = cpu_q.mreq & sram_sel
                                   & (cpu_q.rd | (cpu_q.wr & cpu_q.addr[15]));
            out.rnw              = ~sram_wr;  // Low only for the SRAM write
        end
    end

endmodule

// File: hw/mapper_ascii8.sv
`timescale 1ns/1ns

module mapper_ascii8 #(
    parameter int unsigned ADDR_W = 25
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cart_pkg::cpu_bus_t    cpu_q,
    input  logic                  bank_wr,
    input  cart_pkg::block_info_t block_info,
    output cart_pkg::mapper_out_t out
);

    cart_pkg::bank_t     bank [4];   // Pages 4000h, 6000h, 8000h, A000h
    logic                sel;        // ASCII8 is the active mapper
    logic                in_range;   // 4000h-BFFFh
    logic [1:0]          page;
    cart_pkg::bank_t     cur_bank;
    logic                sram_sel;
    logic                sram_wr;
    cart_pkg::mem_addr_t rom_off;    // Bank times 8 KiB plus offset
    cart_pkg::mem_addr_t sram_addr;
    cart_pkg::mem_addr_t addr_full;

    assign sel      = block_info.typ == cart_pkg::MAPPER_ASCII8;
    assign in_range = cpu_q.addr[15] ^ cpu_q.addr[14];
    assign page     = cpu_q.addr[14:13] - 2'd2;  // 4000h is page 0
    assign cur_bank = bank[page];

    // Bit 7 of the bank turns the page into SRAM
    assign sram_sel = block_info.sram_en & cur_bank[7];
    assign sram_wr  = sram_sel & cpu_q.addr[15] & cpu_q.mreq & cpu_q.wr;  // Upper pages only

    // Bank registers live at 6000h-7FFFh, 2 KiB each
    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '{default: '0};
        end else if (sel && bank_wr && cpu_q.addr[15:13] == 3'b011) begin
            bank[cpu_q.addr[12:11]] <= cpu_q.data;
        end
    end

    assign rom_off   = cart_pkg::mem_addr_t'({cur_bank, cpu_q.addr[12:0]});
    assign sram_addr = block_info.mem_base + cart_pkg::mem_addr_t'(cpu_q.addr[12:0]);
    assign addr_full = sram_sel ? sram_addr
                                : cart_pkg::rom_addr(block_info.mem_base,
                                                     block_info.rom_mask, rom_off);

    always_comb begin
        out      = '0;
        out.addr = '1;    // Idle value for the AND merge
        out.rnw  = 1'b1;
        if (sel && in_range) begin
            out.addr[ADDR_W-1:0] = addr_full[ADDR_W-1:0];
            out.ram_cs           = cpu_q.mreq & cpu_q.rd & ~sram_sel;
            out.sram_cs          = cpu_q.mreq & sram_sel
                                   & (cpu_q.rd | (cpu_q.wr & cpu_q.addr[15]));
            out.rnw              = ~sram_wr;
        end
    end

endmodule

// File: hw/mapper_konami_scc.sv
`timescale 1ns/1ns

module mapper_konami_scc #(
    parameter int unsigned ADDR_W = 25
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cart_pkg::cpu_bus_t    cpu_q,
    input  logic                  bank_wr,
    input  cart_pkg::block_info_t block_info,
    output cart_pkg::mapper_out_t out,
    output logic                  scc_en,
    output logic                  scc_we
);

    cart_pkg::bank_t     bank [4];    // Pages 4000h, 6000h, 8000h, A000h
    logic                sel;
    logic                in_range;
    logic [1:0]          page;
    logic                reg_hit;     // x000h-x7FFh of 5000h, 7000h, 9000h, B000h
    logic                scc_window;  // 9800h-9FFFh with bank 2 at 3Fh
    cart_pkg::mem_addr_t rom_off;
    cart_pkg::mem_addr_t addr_full;

    assign sel      = block_info.typ == cart_pkg::MAPPER_KONAMI_SCC;
    assign in_range = cpu_q.addr[15] ^ cpu_q.addr[14];
    assign page     = cpu_q.addr[14:13] - 2'd2;
    assign reg_hit  = in_range && cpu_q.addr[12:11] == 2'b10;  // Same page decode as reads

    // Banks start as 0..3, a linear 32 KiB image
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= cart_pkg::bank_t'(i);
            end
        end else if (sel && bank_wr && reg_hit) begin
            bank[page] <= cpu_q.data;
        end
    end

    // Sound window replaces the ROM there
    assign scc_window = bank[2] == 8'h3F && cpu_q.addr[15:11] == 5'b10011;

    assign rom_off   = cart_pkg::mem_addr_t'({bank[page], cpu_q.addr[12:0]});
    assign addr_full = cart_pkg::rom_addr(block_info.mem_base, block_info.rom_mask,
                                          rom_off);

    always_comb begin
        out      = '0;        // No SRAM on this board
        out.addr = '1;
        out.rnw  = 1'b1;
        if (sel && in_range && !scc_window) begin
            out.addr[ADDR_W-1:0] = addr_full[ADDR_W-1:0];
            out.ram_cs           = cpu_q.mreq & cpu_q.rd;
        end
    end

    // Device side of the window
    assign scc_en = sel & scc_window & cpu_q.mreq & (cpu_q.rd | cpu_q.wr);
    assign scc_we = scc_en & cpu_q.wr;

endmodule

// File: hw/mapper_merge.sv
`timescale 1ns/1ns

module mapper_merge #(
    parameter int unsigned ADDR_W = 25
) (
    input  cart_pkg::mapper_out_t ascii8_out,
    input  cart_pkg::mapper_out_t ascii16_out,
    input  cart_pkg::mapper_out_t scc_out,
    input  logic                  scc_en,
    input  logic                  scc_we,
    input  cart_pkg::cpu_bus_t    cpu_q,
    input  cart_pkg::block_info_t block_info,
    output cart_pkg::memory_bus_t memory_bus,
    output cart_pkg::device_bus_t device_bus
);

    // Idle mappers drive all ones and zero selects
    // So AND and OR pick the active one
    always_comb begin
        memory_bus.addr               = '1;
        memory_bus.addr[ADDR_W-1:0]   = ascii8_out.addr[ADDR_W-1:0]
                                      & ascii16_out.addr[ADDR_W-1:0]
                                      & scc_out.addr[ADDR_W-1:0];
        memory_bus.ram_cs             = ascii8_out.ram_cs | ascii16_out.ram_cs
                                      | scc_out.ram_cs;
        memory_bus.sram_cs            = ascii8_out.sram_cs | ascii16_out.sram_cs
                                      | scc_out.sram_cs;
        memory_bus.rnw                = ascii8_out.rnw & ascii16_out.rnw
                                      & scc_out.rnw;   // Any write pulls it low
    end

    // Device type follows the slot config during a memory cycle
    assign device_bus.typ = cpu_q.mreq ? block_info.device : cart_pkg::DEV_NONE;
    assign device_bus.en  = scc_en;  // Only SCC sources a device today
    assign device_bus.we  = scc_we;

    // Only one chip select may come from all mappers together
    always_comb begin
        a_cs_onehot: assert final ($onehot0({ascii8_out.ram_cs, ascii8_out.sram_cs,
                                             ascii16_out.ram_cs, ascii16_out.sram_cs,
                                             scc_out.ram_cs, scc_out.sram_cs}))
            else $error("more than one mapper chip select active");
    end

endmodule
